/* Makefile */
# Verilator build and run for the LSU control path testbench

TOP       ?= lsu_ctl_tb
SEED      ?= 14
LOG       ?= sim.log
FILELIST  ?= sources.f
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir
PASS_MSG  := sim passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "Variables: TOP SEED LOG FILELIST VERILATOR OBJ_DIR"

test:
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Run did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* design/lsu_addr_gen.sv */
/* dc1 address generation
   Start and end address, dual-word flag and memory-map decode */
`timescale 1ns/100ps
`default_nettype none

module lsu_addr_gen (
   input  logic [lsu_pkg::XLEN-1:0]        rs1_dc1,
   input  logic [lsu_pkg::OFFSET_W-1:0]    offset_dc1,   // Already zero for atomics
   input  lsu_pkg::size_e                  size_dc1,
   input  logic [lsu_pkg::REGION_HI_W-1:0] dccm_base,
   input  logic [lsu_pkg::REGION_HI_W-1:0] pic_base,
   output logic [lsu_pkg::XLEN-1:0]        lsu_addr_dc1,
   output logic [lsu_pkg::XLEN-1:0]        end_addr_dc1,
   output logic                            ldst_dual_dc1,
   output logic                            addr_in_dccm_dc1,
   output logic                            addr_in_pic_dc1,
   output logic                            addr_external_dc1
);
   import lsu_pkg::*;

   logic [XLEN-1:0]        offset_sext;
   logic [1:0]             size_off;    // Bytes past the first one
   logic [REGION_HI_W-1:0] start_hi;
   logic [REGION_HI_W-1:0] end_hi;

   assign offset_sext  = {{(XLEN-OFFSET_W){offset_dc1[OFFSET_W-1]}}, offset_dc1};
   assign lsu_addr_dc1 = rs1_dc1 + offset_sext;

   always_comb begin
      case (size_dc1)
         SZ_BYTE: size_off = 2'd0;
         SZ_HALF: size_off = 2'd1;
         default: size_off = 2'd3;
      endcase
   end

   assign end_addr_dc1  = lsu_addr_dc1 + {{(XLEN-2){1'b0}}, size_off};
   assign ldst_dual_dc1 = lsu_addr_dc1[2] != end_addr_dc1[2];   // Crosses a word

   //**************************************************************************
   // Region decode
   //**************************************************************************
   assign start_hi = lsu_addr_dc1[XLEN-1 -: REGION_HI_W];
   assign end_hi   = end_addr_dc1[XLEN-1 -: REGION_HI_W];

   // Both ends must land in the same window
   assign addr_in_dccm_dc1  = (start_hi == dccm_base) & (end_hi == dccm_base);
   assign addr_in_pic_dc1   = (start_hi == pic_base) & (end_hi == pic_base);
   assign addr_external_dc1 = ~addr_in_dccm_dc1 & ~addr_in_pic_dc1;

endmodule

`default_nettype wire

/* design/lsu_ctl_top.sv */
/* LSU control path top
   Region config, address generation, pipeline, load format and reservation */
`timescale 1ns/100ps
`default_nettype none

module lsu_ctl_top (
   input  logic                            clk,
   input  logic                            rst_n,
   input  lsu_pkg::lsu_pkt_t               lsu_p,
   input  logic [lsu_pkg::XLEN-1:0]        rs1,
   input  logic [lsu_pkg::OFFSET_W-1:0]    offset,
   input  logic                            flush_dc2_up,
   input  logic                            flush_dc3,
   input  logic                            flush_dc4,
   input  logic                            flush_dc5,
   input  logic [lsu_pkg::XLEN-1:0]        dccm_data,
   input  logic [lsu_pkg::XLEN-1:0]        pic_data,
   input  logic [lsu_pkg::XLEN-1:0]        bus_data,
   input  logic                            lr_reset,
   input  logic                            cfg_req,
   input  logic                            cfg_sel,
   input  logic [lsu_pkg::REGION_HI_W-1:0] cfg_wdata,
   output logic [lsu_pkg::XLEN-1:0]        lsu_addr_dc1,
   output logic                            ldst_dual_dc1,
   output logic                            addr_in_dccm_dc1,
   output logic                            addr_in_pic_dc1,
   output logic                            addr_external_dc1,
   output logic [lsu_pkg::XLEN-1:0]        lsu_result_dc3,
   output logic                            lsu_commit_dc5,
   output logic                            lsu_sc_success_dc5,
   output logic                            lr_vld,
   output logic                            cfg_ack
);
   import lsu_pkg::*;

   logic [REGION_HI_W-1:0] dccm_base, pic_base;
   logic [XLEN-1:0]        rs1_dc1;
   logic [OFFSET_W-1:0]    offset_dc1;
   logic [XLEN-1:0]        end_addr_dc1;
   logic [XLEN-1:0]        lsu_addr_dc5;
   lsu_pkt_t               lsu_pkt_dc1, lsu_pkt_dc3, lsu_pkt_dc5;
   logic                   addr_in_dccm_dc3, addr_in_pic_dc3, addr_external_dc3;

   lsu_region_cfg u_region_cfg (.*);

   lsu_addr_gen u_addr_gen (.*, .size_dc1(lsu_pkt_dc1.size));

   lsu_pipe_ctl u_pipe_ctl (.*, .end_addr_dc5());   // End address unused past dc1 here

   lsu_load_format u_load_format (.*);

   lsu_reservation u_reservation (.*);

endmodule

`default_nettype wire

/* design/lsu_load_format.sv */
/* dc3 load data select by region
   Byte and halfword sign or zero extension */
`timescale 1ns/100ps
`default_nettype none

module lsu_load_format (
   input  lsu_pkg::lsu_pkt_t        lsu_pkt_dc3,
   input  logic                     addr_in_dccm_dc3,
   input  logic                     addr_in_pic_dc3,
   input  logic                     addr_external_dc3,
   input  logic [lsu_pkg::XLEN-1:0] dccm_data,
   input  logic [lsu_pkg::XLEN-1:0] pic_data,
   input  logic [lsu_pkg::XLEN-1:0] bus_data,
   output logic [lsu_pkg::XLEN-1:0] lsu_result_dc3
);
   import lsu_pkg::*;

   logic [XLEN-1:0] ld_data;
   logic            sx;        // Sign extend

   // Region flags are one-hot
   assign ld_data = ({XLEN{addr_in_dccm_dc3}}  & dccm_data) |
                    ({XLEN{addr_in_pic_dc3}}   & pic_data)  |
                    ({XLEN{addr_external_dc3}} & bus_data);
   assign sx      = ~lsu_pkt_dc3.unsign;

   always_comb begin
      lsu_result_dc3 = '0;
      if (lsu_pkt_dc3.valid && lsu_pkt_dc3.load) begin
         case (lsu_pkt_dc3.size)
            SZ_BYTE: lsu_result_dc3 = {{(XLEN-8){sx & ld_data[7]}}, ld_data[7:0]};
            SZ_HALF: lsu_result_dc3 = {{(XLEN-16){sx & ld_data[15]}}, ld_data[15:0]};
            default: lsu_result_dc3 = ld_data;
         endcase
      end
   end

endmodule

`default_nettype wire

/* design/lsu_pipe_ctl.sv */
/* dc1 to dc5 packet, address and region pipeline
   Per-stage flush kill and dc5 commit */
`timescale 1ns/100ps
`default_nettype none

module lsu_pipe_ctl (
   input  logic                         clk,
   input  logic                         rst_n,
   input  lsu_pkg::lsu_pkt_t            lsu_p,
   input  logic [lsu_pkg::XLEN-1:0]     rs1,
   input  logic [lsu_pkg::OFFSET_W-1:0] offset,
   input  logic                         flush_dc2_up,
   input  logic                         flush_dc3,
   input  logic                         flush_dc4,
   input  logic                         flush_dc5,
   input  logic [lsu_pkg::XLEN-1:0]     lsu_addr_dc1,
   input  logic [lsu_pkg::XLEN-1:0]     end_addr_dc1,
   input  logic                         addr_in_dccm_dc1,
   input  logic                         addr_in_pic_dc1,
   input  logic                         addr_external_dc1,
   output logic [lsu_pkg::XLEN-1:0]     rs1_dc1,
   output logic [lsu_pkg::OFFSET_W-1:0] offset_dc1,
   output lsu_pkg::lsu_pkt_t            lsu_pkt_dc1,
   output lsu_pkg::lsu_pkt_t            lsu_pkt_dc3,
   output lsu_pkg::lsu_pkt_t            lsu_pkt_dc5,
   output logic [lsu_pkg::XLEN-1:0]     lsu_addr_dc5,
   output logic [lsu_pkg::XLEN-1:0]     end_addr_dc5,
   output logic                         addr_in_dccm_dc3,
   output logic                         addr_in_pic_dc3,
   output logic                         addr_external_dc3,
   output logic                         lsu_commit_dc5
);
   import lsu_pkg::*;

   lsu_pkt_t        pkt_in [1:5];
   lsu_pkt_t        pkt_q  [1:5];
   logic [XLEN-1:0] addr_q [2:5];
   logic [XLEN-1:0] end_q  [2:5];
   logic [3:2]      dccm_q, pic_q, ext_q;   // Region flags for dc2 and dc3

   // Packet moves down one stage per clock, valid killed by flushes
   always_comb begin
      pkt_in[1] = lsu_p;
      for (int i = 2; i <= 5; i++) begin
         pkt_in[i] = pkt_q[i-1];
      end
      pkt_in[1].valid = lsu_p.valid & ~flush_dc2_up;
      pkt_in[2].valid = pkt_q[1].valid & ~flush_dc2_up;
      pkt_in[3].valid = pkt_q[2].valid & ~flush_dc2_up;
      pkt_in[4].valid = pkt_q[3].valid & ~flush_dc3;
      pkt_in[5].valid = pkt_q[4].valid & ~flush_dc4;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 1; i <= 5; i++) begin
            pkt_q[i] <= '0;
         end
      end else begin
         pkt_q <= pkt_in;
      end
   end

   //**************************************************************************
   // Operand, address and region flops
   //**************************************************************************
   always_ff @(posedge clk) begin
      rs1_dc1    <= rs1;
      offset_dc1 <= offset & ~{OFFSET_W{lsu_p.atomic}};   // Atomics use rs1 only
      addr_q[2]  <= lsu_addr_dc1;
      end_q[2]   <= end_addr_dc1;
      for (int i = 3; i <= 5; i++) begin
         addr_q[i] <= addr_q[i-1];
         end_q[i]  <= end_q[i-1];
      end
      dccm_q <= {dccm_q[2], addr_in_dccm_dc1};
      pic_q  <= {pic_q[2], addr_in_pic_dc1};
      ext_q  <= {ext_q[2], addr_external_dc1};
   end

   assign lsu_pkt_dc1       = pkt_q[1];
   assign lsu_pkt_dc3       = pkt_q[3];
   assign lsu_pkt_dc5       = pkt_q[5];
   assign lsu_addr_dc5      = addr_q[5];
   assign end_addr_dc5      = end_q[5];
   assign addr_in_dccm_dc3  = dccm_q[3];
   assign addr_in_pic_dc3   = pic_q[3];
   assign addr_external_dc3 = ext_q[3];

   assign lsu_commit_dc5 = pkt_q[5].valid & ~flush_dc5 &
                           (pkt_q[5].load | pkt_q[5].store | pkt_q[5].atomic);

endmodule

`default_nettype wire

/* design/lsu_pkg.sv */
/* Shared widths, size codes and region constants for the LSU control path
   LSU packet carried from decode down to dc5 */
`default_nettype none

package lsu_pkg;

   //**************************************************************************
   // Widths
   //**************************************************************************
   localparam int XLEN        = 32;   // Data and address width
   localparam int OFFSET_W    = 12;   // Immediate offset
   localparam int REGION_HI_W = 16;   // Upper address bits, 64 KB per region

   // Region bases out of reset
   localparam logic [REGION_HI_W-1:0] DCCM_BASE_RST = 16'hF004;
   localparam logic [REGION_HI_W-1:0] PIC_BASE_RST  = 16'hF00C;

   // Config register select
   localparam logic CFG_SEL_DCCM = 1'b0;
   localparam logic CFG_SEL_PIC  = 1'b1;

   //**************************************************************************
   // Access size and packet
   //**************************************************************************
   typedef enum logic [1:0] {
      SZ_BYTE = 2'b00,
      SZ_HALF = 2'b01,
      SZ_WORD = 2'b10
   } size_e;

   // Valid sits in bit 0
   typedef struct packed {
      logic  atomic;   // Any AMO, LR or SC
      logic  sc;
      logic  lr;
      size_e size;
      logic  unsign;   // Zero extend on load
      logic  store;
      logic  load;
      logic  valid;
   } lsu_pkt_t;

endpackage

`default_nettype wire

/* design/lsu_region_cfg.sv */
/* DCCM and PIC base registers
   Written by a four-phase req/ack handshake */
`timescale 1ns/100ps
`default_nettype none

module lsu_region_cfg (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            cfg_req,
   input  logic                            cfg_sel,
   input  logic [lsu_pkg::REGION_HI_W-1:0] cfg_wdata,
   output logic                            cfg_ack,
   output logic [lsu_pkg::REGION_HI_W-1:0] dccm_base,
   output logic [lsu_pkg::REGION_HI_W-1:0] pic_base
);
   import lsu_pkg::*;

   logic cfg_wr;

   // New request seen, not yet acknowledged
   assign cfg_wr = cfg_req & ~cfg_ack;

   // Ack follows req one edge later, both ways
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cfg_ack <= 1'b0;
      end else if (cfg_wr) begin
         cfg_ack <= 1'b1;
      end else if (!cfg_req) begin
         cfg_ack <= 1'b0;   // Master has released req
      end
   end

   //**************************************************************************
   // Base registers
   //**************************************************************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         dccm_base <= DCCM_BASE_RST;
         pic_base  <= PIC_BASE_RST;
      end else if (cfg_wr) begin
         if (cfg_sel == CFG_SEL_DCCM) begin
            dccm_base <= cfg_wdata;
         end
         if (cfg_sel == CFG_SEL_PIC) begin
            pic_base <= cfg_wdata;
         end
      end
   end

endmodule

`default_nettype wire

/* design/lsu_reservation.sv */
/* LR/SC reservation, one address and valid
   SC success check in dc5 */
`timescale 1ns/100ps
`default_nettype none

module lsu_reservation (
   input  logic                     clk,
   input  logic                     rst_n,
   input  lsu_pkg::lsu_pkt_t        lsu_pkt_dc5,
   input  logic [lsu_pkg::XLEN-1:0] lsu_addr_dc5,
   input  logic                     lsu_commit_dc5,
   input  logic                     lr_reset,      // Interrupt, debug or trap
   output logic                     lr_vld,
   output logic                     lsu_sc_success_dc5
);
   import lsu_pkg::*;

   logic [XLEN-1:2] lr_addr;   // Word granule
   logic            lr_wr_en;
   logic            lr_clr;

   assign lr_wr_en = lsu_commit_dc5 & lsu_pkt_dc5.lr;
   assign lr_clr   = (lsu_commit_dc5 & lsu_pkt_dc5.sc) | lr_reset;   // Any SC, match or not

   assign lsu_sc_success_dc5 = lsu_pkt_dc5.valid & lsu_pkt_dc5.sc & lr_vld &
                               (lsu_addr_dc5[XLEN-1:2] == lr_addr);

   // Clear wins over set
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         lr_vld <= 1'b0;
      end else if (lr_clr) begin
         lr_vld <= 1'b0;
      end else if (lr_wr_en) begin
         lr_vld <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (lr_wr_en) begin
         lr_addr <= lsu_addr_dc5[XLEN-1:2];
      end
   end

endmodule

`default_nettype wire

/* dv/lsu_ctl_checker.sv */
/* Response checker for the LSU control path
   Samples dc1, dc3 and dc5 outputs of each posted op */
`timescale 1ns/100ps
`default_nettype none

module lsu_ctl_checker (
   input  logic                     clk,
   input  logic                     post,         // New op issued this cycle
   input  int                       test_id,
   input  logic [lsu_pkg::XLEN-1:0] exp_addr,
   input  logic                     exp_dual,
   input  logic [2:0]               exp_region,   // {ext, pic, dccm}
   input  logic [lsu_pkg::XLEN-1:0] exp_result,
   input  logic [2:0]               exp_status,   // {commit, sc success, lr_vld}
   input  logic [lsu_pkg::XLEN-1:0] lsu_addr_dc1,
   input  logic                     ldst_dual_dc1,
   input  logic                     addr_in_dccm_dc1,
   input  logic                     addr_in_pic_dc1,
   input  logic                     addr_external_dc1,
   input  logic [lsu_pkg::XLEN-1:0] lsu_result_dc3,
   input  logic                     lsu_commit_dc5,
   input  logic                     lsu_sc_success_dc5,
   input  logic                     lr_vld,
   output int                       tests_done,
   output int                       tests_failed
);
   import lsu_pkg::*;

   int              n_done = 0;
   int              n_fail = 0;
   int              id;
   int              cyc;
   int              errs;
   logic            busy = 1'b0;
   logic [XLEN-1:0] e_addr;
   logic [XLEN-1:0] e_res;
   logic            e_dual;
   logic [2:0]      e_reg;
   logic [2:0]      e_st;

   assign tests_done   = n_done;
   assign tests_failed = n_fail;

   task automatic compare_field(input string what, input logic [XLEN-1:0] got,
                                input logic [XLEN-1:0] exp);
      if (got !== exp) begin
         $display("[FAIL] %0t test %0d: %s is %h, expected %h", $time, id, what, got, exp);
         errs++;
      end
   endtask

   // Cycles counted from the issue edge, sampled mid-cycle
   always @(negedge clk) begin
      if (post) begin
         id     = test_id;
         e_addr = exp_addr;
         e_dual = exp_dual;
         e_reg  = exp_region;
         e_res  = exp_result;
         e_st   = exp_status;
         cyc    = 0;
         errs   = 0;
         busy   = 1'b1;
      end else if (busy) begin
         cyc++;
         case (cyc)
            1: begin
               compare_field("lsu_addr_dc1", lsu_addr_dc1, e_addr);
               compare_field("ldst_dual_dc1", 32'(ldst_dual_dc1), 32'(e_dual));
               compare_field("region flags",
                  32'({addr_external_dc1, addr_in_pic_dc1, addr_in_dccm_dc1}), 32'(e_reg));
            end
            3: compare_field("lsu_result_dc3", lsu_result_dc3, e_res);
            5: begin
               compare_field("lsu_commit_dc5", 32'(lsu_commit_dc5), 32'(e_st[2]));
               compare_field("lsu_sc_success_dc5", 32'(lsu_sc_success_dc5), 32'(e_st[1]));
            end
            6: begin   // Reservation has taken the dc5 update
               compare_field("lr_vld", 32'(lr_vld), 32'(e_st[0]));
               n_done++;
               if (errs != 0) begin
                  n_fail++;
               end
               $display("test %0d %s", id, (errs == 0) ? "pass" : "fail");
               busy = 1'b0;
            end
            default: ;
         endcase
      end
   end

endmodule

`default_nettype wire

/* dv/lsu_ctl_tb.sv */
/* Testbench for the LSU control path
   Region config writes, then a stimulus table applied one op at a time */
`timescale 1ns/100ps
`default_nettype none

module lsu_ctl_tb;
   import lsu_pkg::*;

   localparam int N_TESTS = 28;
   localparam int TIMEOUT = 20;   // Cycles allowed per wait

   localparam logic [1:0] R_EXT = 2'd0;
   localparam logic [1:0] R_DC  = 2'd1;
   localparam logic [1:0] R_PIC = 2'd2;

   // Byte and half signs differ per region
   localparam logic [XLEN-1:0] DCCM_W = 32'h1234_5680;
   localparam logic [XLEN-1:0] PIC_W  = 32'hCAFE_F07F;
   localparam logic [XLEN-1:0] BUS_W  = 32'h89AB_CDEF;

   // atomic, sc, lr, size, unsign, store, load, valid
   localparam lsu_pkt_t LB  = '{1'b0, 1'b0, 1'b0, SZ_BYTE, 1'b0, 1'b0, 1'b1, 1'b1};
   localparam lsu_pkt_t LBU = '{1'b0, 1'b0, 1'b0, SZ_BYTE, 1'b1, 1'b0, 1'b1, 1'b1};
   localparam lsu_pkt_t LH  = '{1'b0, 1'b0, 1'b0, SZ_HALF, 1'b0, 1'b0, 1'b1, 1'b1};
   localparam lsu_pkt_t LHU = '{1'b0, 1'b0, 1'b0, SZ_HALF, 1'b1, 1'b0, 1'b1, 1'b1};
   localparam lsu_pkt_t LW  = '{1'b0, 1'b0, 1'b0, SZ_WORD, 1'b0, 1'b0, 1'b1, 1'b1};
   localparam lsu_pkt_t SB  = '{1'b0, 1'b0, 1'b0, SZ_BYTE, 1'b0, 1'b1, 1'b0, 1'b1};
   localparam lsu_pkt_t LR  = '{1'b1, 1'b0, 1'b1, SZ_WORD, 1'b0, 1'b0, 1'b1, 1'b1};
   localparam lsu_pkt_t SC  = '{1'b1, 1'b1, 1'b0, SZ_WORD, 1'b0, 1'b1, 1'b0, 1'b1};
   localparam lsu_pkt_t NOP = '0;

   typedef struct packed {
      lsu_pkt_t            p;
      logic [XLEN-1:0]     rs1;
      logic [OFFSET_W-1:0] off;
      logic [2:0]          fl;    // Flush stage or 0 for none
      logic [1:0]          ctl;   // {lr_reset, random rs1}
      logic [1:0]          er;    // Expected region
      logic [XLEN-1:0]     res;
      logic [2:0]          ex;    // {commit, sc success, lr_vld}
   } entry_t;

   logic                   clk = 1'b0;
   logic                   rst_n;
   lsu_pkt_t               lsu_p;
   logic [XLEN-1:0]        rs1, dccm_data, pic_data, bus_data;
   logic [OFFSET_W-1:0]    offset;
   logic                   flush_dc2_up, flush_dc3, flush_dc4, flush_dc5;
   logic                   lr_reset, cfg_req, cfg_sel, cfg_ack;
   logic [REGION_HI_W-1:0] cfg_wdata;
   logic [XLEN-1:0]        lsu_addr_dc1, lsu_result_dc3;
   logic                   ldst_dual_dc1, addr_in_dccm_dc1, addr_in_pic_dc1;
   logic                   addr_external_dc1, lsu_commit_dc5, lsu_sc_success_dc5, lr_vld;
   logic                   post, exp_dual;
   int                     test_id, tests_done, tests_failed;
   int                     hs_errs = 0;
   logic [XLEN-1:0]        exp_addr, exp_result;
   logic [2:0]             exp_region, exp_status;
   entry_t                 tbl [N_TESTS];

   always #4 clk = ~clk;

   lsu_ctl_top UUT (.*);

   lsu_ctl_checker chk (.*);

   // Atomics ignore the offset
   function automatic logic [XLEN-1:0] expected_addr(input lsu_pkt_t p,
         input logic [XLEN-1:0] base, input logic [OFFSET_W-1:0] off);
      logic [XLEN-1:0] disp;
      disp = p.atomic ? '0 : {{(XLEN-OFFSET_W){off[OFFSET_W-1]}}, off};
      return base + disp;
   endfunction

   function automatic logic crosses_word(input logic [XLEN-1:0] a, input size_e sz);
      logic [XLEN-1:0] last;
      case (sz)
         SZ_BYTE: last = a;
         SZ_HALF: last = a + 32'd1;
         default: last = a + 32'd3;
      endcase
      return a[2] != last[2];
   endfunction

   function automatic logic [2:0] region_bits(input logic [1:0] r);
      return (r == R_DC) ? 3'b001 : (r == R_PIC) ? 3'b010 : 3'b100;
   endfunction

   //**************************************************************************
   // Stimulus table with DCCM at A000 and PIC at B000 after config
   //**************************************************************************
   task automatic load_table();
      tbl[ 0] = '{LW,  32'h0000_0000, 12'h7F0, 3'd0, 2'b01, R_EXT, BUS_W,         3'b100};
      tbl[ 1] = '{SB,  32'h0000_0000, 12'hFFC, 3'd0, 2'b01, R_EXT, 32'h0000_0000, 3'b100};
      tbl[ 2] = '{LB,  32'hA000_0010, 12'h000, 3'd0, 2'b00, R_DC,  32'hFFFF_FF80, 3'b100};
      tbl[ 3] = '{LBU, 32'hA000_0011, 12'h000, 3'd0, 2'b00, R_DC,  32'h0000_0080, 3'b100};
      tbl[ 4] = '{LH,  32'hA000_0020, 12'hFFE, 3'd0, 2'b00, R_DC,  32'h0000_5680, 3'b100};
      tbl[ 5] = '{LHU, 32'hB000_0004, 12'h002, 3'd0, 2'b00, R_PIC, 32'h0000_F07F, 3'b100};
      tbl[ 6] = '{LB,  32'hB000_0000, 12'h001, 3'd0, 2'b00, R_PIC, 32'h0000_007F, 3'b100};
      tbl[ 7] = '{LH,  32'hB000_0008, 12'h000, 3'd0, 2'b00, R_PIC, 32'hFFFF_F07F, 3'b100};
      tbl[ 8] = '{LW,  32'hA000_FFFC, 12'h002, 3'd0, 2'b00, R_EXT, BUS_W,         3'b100};
      tbl[ 9] = '{LW,  32'hC000_0000, 12'h010, 3'd0, 2'b00, R_EXT, BUS_W,         3'b100};
      tbl[10] = '{LHU, 32'hA000_0002, 12'h000, 3'd0, 2'b00, R_DC,  32'h0000_5680, 3'b100};
      tbl[11] = '{LBU, 32'hB000_0003, 12'h000, 3'd0, 2'b00, R_PIC, 32'h0000_007F, 3'b100};
      tbl[12] = '{LW,  32'hB000_0000, 12'h000, 3'd0, 2'b00, R_PIC, PIC_W,         3'b100};
      tbl[13] = '{LB,  32'hC000_0000, 12'h000, 3'd0, 2'b00, R_EXT, 32'hFFFF_FFEF, 3'b100};
      tbl[14] = '{LBU, 32'hC000_0001, 12'h000, 3'd0, 2'b00, R_EXT, 32'h0000_00EF, 3'b100};
      tbl[15] = '{LH,  32'hC000_0002, 12'h000, 3'd0, 2'b00, R_EXT, 32'hFFFF_CDEF, 3'b100};
      tbl[16] = '{LHU, 32'hC000_0004, 12'h000, 3'd0, 2'b00, R_EXT, 32'h0000_CDEF, 3'b100};
      tbl[17] = '{LW,  32'hA000_0000, 12'h000, 3'd2, 2'b00, R_DC,  32'h0000_0000, 3'b000};
      tbl[18] = '{LW,  32'hA000_0000, 12'h000, 3'd3, 2'b00, R_DC,  DCCM_W,        3'b000};
      tbl[19] = '{LW,  32'hA000_0000, 12'h000, 3'd4, 2'b00, R_DC,  DCCM_W,        3'b000};
      tbl[20] = '{LW,  32'hA000_0000, 12'h000, 3'd5, 2'b00, R_DC,  DCCM_W,        3'b000};
      tbl[21] = '{LR,  32'hA000_0100, 12'h010, 3'd0, 2'b00, R_DC,  DCCM_W,        3'b101};
      tbl[22] = '{SC,  32'hA000_0104, 12'h000, 3'd0, 2'b00, R_DC,  32'h0000_0000, 3'b100};
      tbl[23] = '{LR,  32'hA000_0200, 12'h000, 3'd0, 2'b00, R_DC,  DCCM_W,        3'b101};
      tbl[24] = '{SC,  32'hA000_0202, 12'h000, 3'd0, 2'b00, R_DC,  32'h0000_0000, 3'b110};
      tbl[25] = '{SC,  32'hA000_0200, 12'h000, 3'd0, 2'b00, R_DC,  32'h0000_0000, 3'b100};
      tbl[26] = '{LR,  32'hA000_0300, 12'h000, 3'd0, 2'b00, R_DC,  DCCM_W,        3'b101};
      tbl[27] = '{NOP, 32'h0000_0000, 12'h000, 3'd0, 2'b10, R_EXT, 32'h0000_0000, 3'b000};
   endtask

   task automatic write_cfg(input logic sel, input logic [REGION_HI_W-1:0] data);
      int t;
      @(posedge clk);
      cfg_sel   <= sel;
      cfg_wdata <= data;
      cfg_req   <= 1'b1;
      t = 0;
      while (cfg_ack !== 1'b1 && t < TIMEOUT) begin
         @(negedge clk);
         t++;
      end
      if (cfg_ack !== 1'b1) begin
         $display("Config write: cfg_ack never rose after cfg_req");
         hs_errs++;
      end
      @(posedge clk);
      cfg_req <= 1'b0;
      @(negedge clk);
      if (cfg_ack !== 1'b1) begin
         $display("Config write: cfg_ack fell before cfg_req was released");
         hs_errs++;
      end
      t = 0;
      while (cfg_ack !== 1'b0 && t < TIMEOUT) begin
         @(negedge clk);
         t++;
      end
      if (cfg_ack !== 1'b0) begin
         $display("Config write: cfg_ack stayed high after cfg_req dropped");
         hs_errs++;
      end
   endtask

   task automatic run_entry(input int i);
      entry_t          e;
      logic [XLEN-1:0] a;
      int              c;
      int              start;
      e = tbl[i];
      if (e.ctl[0]) begin
         e.rs1 = 32'h2000_0000 | ($urandom & 32'h0000_FFFF);   // Stays external
      end
      a = expected_addr(e.p, e.rs1, e.off);
      start = tests_done;
      @(posedge clk);
      lsu_p      <= e.p;
      rs1        <= e.rs1;
      offset     <= e.off;
      lr_reset   <= e.ctl[1];
      post       <= 1'b1;
      test_id    <= i;
      exp_addr   <= a;
      exp_dual   <= crosses_word(a, e.p.size);
      exp_region <= region_bits(e.er);
      exp_result <= e.res;
      exp_status <= e.ex;
      c = 0;
      do begin   // Flush strobes land while the op sits in the named stage
         @(posedge clk);
         c++;
         lsu_p        <= NOP;
         lr_reset     <= 1'b0;
         post         <= 1'b0;
         flush_dc2_up <= (e.fl == 3'd2) && (c == 1);
         flush_dc3    <= (e.fl == 3'd3) && (c == 3);
         flush_dc4    <= (e.fl == 3'd4) && (c == 4);
         flush_dc5    <= (e.fl == 3'd5) && (c == 5);
      end while (tests_done == start && c < TIMEOUT);
      if (tests_done == start) begin
         $display("No result from the checker for test %0d within %0d cycles", i, TIMEOUT);
         hs_errs++;
      end
   endtask

   //**************************************************************************
   // Main sequence
   //**************************************************************************
   initial begin
      void'($urandom(14));
      rst_n        <= 1'b0;
      lsu_p        <= NOP;
      rs1          <= '0;
      offset       <= '0;
      flush_dc2_up <= 1'b0;
      flush_dc3    <= 1'b0;
      flush_dc4    <= 1'b0;
      flush_dc5    <= 1'b0;
      dccm_data    <= DCCM_W;
      pic_data     <= PIC_W;
      bus_data     <= BUS_W;
      lr_reset     <= 1'b0;
      cfg_req      <= 1'b0;
      cfg_sel      <= 1'b0;
      cfg_wdata    <= '0;
      post         <= 1'b0;
      test_id      <= 0;
      exp_addr     <= '0;
      exp_dual     <= 1'b0;
      exp_region   <= '0;
      exp_result   <= '0;
      exp_status   <= '0;
      load_table();
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      if (cfg_ack !== 1'b0) begin
         $display("cfg_ack is high right after reset");
         hs_errs++;
      end
      write_cfg(CFG_SEL_DCCM, 16'hA000);
      write_cfg(CFG_SEL_PIC, 16'hB000);
      for (int i = 0; i < N_TESTS; i++) begin
         run_entry(i);
      end
      $display("tests run %0d of %0d, failed %0d, handshake errors %0d",
               tests_done, N_TESTS, tests_failed, hs_errs);
      if (tests_failed == 0 && hs_errs == 0 && tests_done == N_TESTS) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* sources.f */
design/lsu_pkg.sv
design/lsu_region_cfg.sv
design/lsu_addr_gen.sv
design/lsu_pipe_ctl.sv
design/lsu_load_format.sv
design/lsu_reservation.sv
design/lsu_ctl_top.sv
dv/lsu_ctl_checker.sv
dv/lsu_ctl_tb.sv
